/* src/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// address and word width
`define XLEN 32

// one memory reply carries a 64-bit block
`define BLOCK_BITS 64

// transaction tag width
// tag 0 means no transaction
`define MEM_TAG_BITS 4

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

/* src/mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

    // command on the shared memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    // access size, byte up to a full block
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    // which side sent the last bus request
    typedef enum logic [1:0] {
        OWN_NONE = 2'h0,
        OWN_D    = 2'h1,
        OWN_I    = 2'h2
    } mem_owner_t;

    // IF/ID packet
    // npc is always pc + 4 here, no prediction
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] inst;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] npc;
    } fetch_packet_t;

endpackage

/* src/mem_port_if.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

// one client's view of the shared memory bus
interface mem_port_if;

    // request side, driven by the client
    mem_pkg::bus_command_t     command;
    logic [`XLEN-1:0]          addr;
    logic [`XLEN-1:0]          data;
    mem_pkg::mem_size_t        size;

    // accept tag, 0 when rejected or not granted
    logic [`MEM_TAG_BITS-1:0]  response;

    // late reply, seen by every client
    logic [`MEM_TAG_BITS-1:0]  reply_tag;
    logic [`BLOCK_BITS-1:0]    reply_data;

    modport client (
        output command, addr, data, size,
        input  response, reply_tag, reply_data
    );

    modport arbiter (
        input  command, addr, data, size,
        output response, reply_tag, reply_data
    );

endinterface

/* src/mem_arbiter.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_arbiter (
    input  logic                      clock,
    input  logic                      reset,
    mem_port_if.arbiter               i_port,
    mem_port_if.arbiter               d_port,
    output mem_pkg::bus_command_t     mem_command,
    output logic [`XLEN-1:0]          mem_addr,
    output logic [`BLOCK_BITS-1:0]    mem_data,
    output mem_pkg::mem_size_t        mem_size,
    input  logic [`MEM_TAG_BITS-1:0]  mem_response,
    input  logic [`MEM_TAG_BITS-1:0]  mem_reply_tag,
    input  logic [`BLOCK_BITS-1:0]    mem_reply_data,
    output logic                      fetch_stall
);

    mem_pkg::mem_owner_t grant;
    mem_pkg::mem_owner_t owner_q;
    logic [`XLEN-1:0]    store_word;

    ////////////////////////////////////////
    // grant, data side first
    ////////////////////////////////////////
    always_comb begin
        if (d_port.command != mem_pkg::BUS_NONE) begin
            grant = mem_pkg::OWN_D;
        end else if (i_port.command != mem_pkg::BUS_NONE) begin
            grant = mem_pkg::OWN_I;
        end else begin
            grant = mem_pkg::OWN_NONE;
        end
    end

    // bus mux, fetch asks for a DOUBLE load by itself
    always_comb begin
        mem_command = mem_pkg::BUS_NONE;
        mem_addr    = '0;
        mem_size    = mem_pkg::BYTE;
        store_word  = '0;
        case (grant)
            mem_pkg::OWN_D: begin
                mem_command = d_port.command;
                mem_addr    = d_port.addr;
                mem_size    = d_port.size;
                store_word  = d_port.data;
            end
            mem_pkg::OWN_I: begin
                mem_command = i_port.command;
                mem_addr    = i_port.addr;
                mem_size    = i_port.size;
                store_word  = i_port.data;
            end
            default: begin
            end
        endcase
    end

    // store data zero-extended into the block word
    assign mem_data = {{(`BLOCK_BITS - `XLEN){1'b0}}, store_word};

    ////////////////////////////////////////
    // response routing
    ////////////////////////////////////////
    // accept tag only to the side granted this cycle
    assign d_port.response = (grant == mem_pkg::OWN_D) ? mem_response : '0;
    assign i_port.response = (grant == mem_pkg::OWN_I) ? mem_response : '0;

    // replies go to both, each side matches its own tag
    assign d_port.reply_tag  = mem_reply_tag;
    assign d_port.reply_data = mem_reply_data;
    assign i_port.reply_tag  = mem_reply_tag;
    assign i_port.reply_data = mem_reply_data;

    // last cycle's owner, dropped once accepted
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner_q <= mem_pkg::OWN_NONE;
        end else if (mem_response != '0) begin
            owner_q <= mem_pkg::OWN_NONE;
        end else begin
            owner_q <= grant;
        end
    end

    // data holds the bus now, or was rejected last cycle and retries
    assign fetch_stall = (grant == mem_pkg::OWN_D) || (owner_q == mem_pkg::OWN_D);

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module fetch_unit (
    input  logic                    clock,
    input  logic                    reset,
    mem_port_if.client              port,
    input  logic                    redirect,
    input  logic [`XLEN-1:0]        redirect_pc,
    output mem_pkg::fetch_packet_t  fetch_packet
);

    logic [`XLEN-1:0]          pc_q;
    logic                      live_q;
    logic                      waiting_q;
    logic [`MEM_TAG_BITS-1:0]  tag_q;
    logic                      valid_q;
    logic [`XLEN-1:0]          inst_q;
    logic [`XLEN-1:0]          pkt_pc_q;
    logic                      issue;
    logic                      accepted;
    logic                      hit;
    logic [`XLEN-1:0]          word;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////
    // one request in flight at most
    // quiet for the first cycle out of reset
    assign issue    = live_q && !waiting_q;
    assign accepted = issue && (port.response != '0);

    // aligned block load, word picked on reply
    assign port.command = issue ? mem_pkg::BUS_LOAD : mem_pkg::BUS_NONE;
    assign port.addr    = {pc_q[`XLEN-1:3], 3'b000};
    assign port.data    = '0;
    assign port.size    = mem_pkg::DOUBLE;

    ////////////////////////////////////////
    // reply side
    ////////////////////////////////////////
    assign hit  = waiting_q && (port.reply_tag == tag_q);
    // pc bit 2 selects upper or lower word
    assign word = pc_q[2] ? port.reply_data[`BLOCK_BITS-1:`XLEN]
                          : port.reply_data[`XLEN-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_q      <= `RESET_PC;
            live_q    <= 1'b0;
            waiting_q <= 1'b0;
            tag_q     <= '0;
            valid_q   <= 1'b0;
        end else begin
            live_q  <= 1'b1;
            valid_q <= 1'b0;
            if (redirect) begin
                // new pc, any reply in flight is dropped
                pc_q      <= redirect_pc;
                waiting_q <= 1'b0;
            end else if (hit) begin
                pc_q      <= pc_q + `XLEN'(4);
                waiting_q <= 1'b0;
                valid_q   <= 1'b1;
            end else if (accepted) begin
                waiting_q <= 1'b1;
                tag_q     <= port.response;
            end
        end
    end

    // packet payload
    always_ff @(posedge clock) begin
        if (hit) begin
            inst_q   <= word;
            pkt_pc_q <= pc_q;
        end
    end

    assign fetch_packet.valid = valid_q;
    assign fetch_packet.inst  = inst_q;
    assign fetch_packet.pc    = pkt_pc_q;
    assign fetch_packet.npc   = pkt_pc_q + `XLEN'(4);

endmodule

/* src/data_port.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module data_port (
    input  logic                   clock,
    input  logic                   reset,
    mem_port_if.client             port,
    input  mem_pkg::bus_command_t  dmem_command,
    input  logic [`XLEN-1:0]       dmem_addr,
    input  logic [`XLEN-1:0]       dmem_wdata,
    input  mem_pkg::mem_size_t     dmem_size,
    output logic                   dmem_busy,
    output logic                   dmem_done,
    output logic [`XLEN-1:0]       dmem_rdata
);

    logic                      pend_q;
    logic                      wait_q;
    logic                      done_q;
    mem_pkg::bus_command_t     cmd_q;
    mem_pkg::mem_size_t        size_q;
    logic [`XLEN-1:0]          addr_q;
    logic [`XLEN-1:0]          wdata_q;
    logic [`MEM_TAG_BITS-1:0]  tag_q;
    logic [`XLEN-1:0]          rdata_q;
    logic                      take;
    logic                      accepted;
    logic                      hit;

    // pend: on the bus, wait: load accepted, reply due
    assign dmem_busy = pend_q || wait_q;
    assign take      = !dmem_busy && (dmem_command != mem_pkg::BUS_NONE);
    assign accepted  = pend_q && (port.response != '0);
    assign hit       = wait_q && (port.reply_tag == tag_q);

    // held request, kept up until a nonzero response
    assign port.command = pend_q ? cmd_q : mem_pkg::BUS_NONE;
    assign port.addr    = addr_q;
    assign port.data    = wdata_q;
    assign port.size    = size_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pend_q <= 1'b0;
            wait_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (take) begin
                pend_q <= 1'b1;
            end else if (accepted) begin
                pend_q <= 1'b0;
                // store is done once accepted
                if (cmd_q == mem_pkg::BUS_STORE) begin
                    done_q <= 1'b1;
                end else begin
                    wait_q <= 1'b1;
                end
            end else if (hit) begin
                wait_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // request and reply payload
    always_ff @(posedge clock) begin
        if (take) begin
            cmd_q   <= dmem_command;
            addr_q  <= dmem_addr;
            wdata_q <= dmem_wdata;
            size_q  <= dmem_size;
        end
        if (accepted) begin
            tag_q <= port.response;
        end
        if (hit) begin
            // addr bit 2 picks the word
            rdata_q <= addr_q[2] ? port.reply_data[`BLOCK_BITS-1:`XLEN]
                                 : port.reply_data[`XLEN-1:0];
        end
    end

    assign dmem_done  = done_q;
    assign dmem_rdata = rdata_q;

endmodule

/* src/mem_front.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_front (
    input  logic                      clock,
    input  logic                      reset,
    // memory bus
    output mem_pkg::bus_command_t     mem_command,
    output logic [`XLEN-1:0]          mem_addr,
    output logic [`BLOCK_BITS-1:0]    mem_data,
    output mem_pkg::mem_size_t        mem_size,
    input  logic [`MEM_TAG_BITS-1:0]  mem_response,
    input  logic [`MEM_TAG_BITS-1:0]  mem_reply_tag,
    input  logic [`BLOCK_BITS-1:0]    mem_reply_data,
    // data requests
    input  mem_pkg::bus_command_t     dmem_command,
    input  logic [`XLEN-1:0]          dmem_addr,
    input  logic [`XLEN-1:0]          dmem_wdata,
    input  mem_pkg::mem_size_t        dmem_size,
    output logic                      dmem_busy,
    output logic                      dmem_done,
    output logic [`XLEN-1:0]          dmem_rdata,
    // fetch
    input  logic                      redirect,
    input  logic [`XLEN-1:0]          redirect_pc,
    output mem_pkg::fetch_packet_t    fetch_packet,
    output logic                      fetch_stall
);

    // fetch and data sides of the shared bus
    mem_port_if i_port ();
    mem_port_if d_port ();

    mem_arbiter u_mem_arbiter (
        .clock          (clock),
        .reset          (reset),
        .i_port         (i_port.arbiter),
        .d_port         (d_port.arbiter),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_size       (mem_size),
        .mem_response   (mem_response),
        .mem_reply_tag  (mem_reply_tag),
        .mem_reply_data (mem_reply_data),
        .fetch_stall    (fetch_stall)
    );

    fetch_unit u_fetch_unit (
        .clock        (clock),
        .reset        (reset),
        .port         (i_port.client),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .fetch_packet (fetch_packet)
    );

    data_port u_data_port (
        .clock        (clock),
        .reset        (reset),
        .port         (d_port.client),
        .dmem_command (dmem_command),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_size    (dmem_size),
        .dmem_busy    (dmem_busy),
        .dmem_done    (dmem_done),
        .dmem_rdata   (dmem_rdata)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // reset rises just after time zero so every async reset flop sees the edge
    // released on a clock edge
    initial begin
        reset = 1'b0;
        #1;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* tests/mem_front_asserts.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_front_asserts (
    input logic                    clock,
    input logic                    reset,
    input mem_pkg::bus_command_t   mem_command,
    input logic [`BLOCK_BITS-1:0]  mem_data,
    input mem_pkg::mem_size_t      mem_size,
    input mem_pkg::bus_command_t   d_command,
    input logic                    dmem_busy,
    input logic                    dmem_done,
    input logic                    fetch_valid,
    input logic                    fetch_stall
);

    // failures seen so far, read by the testbench top
    int fail_count = 0;

    // quiet bus and outputs in reset and the first cycle out of it
    reset_quiet: assert property (@(posedge clock)
        (reset || $fell(reset)) |-> (mem_command == mem_pkg::BUS_NONE) && !dmem_busy
            && !dmem_done && !fetch_valid && !fetch_stall)
        else begin
            fail_count++;
            $error("outputs not idle around reset");
        end

    // data side wins the bus
    data_priority: assert property (@(posedge clock) disable iff (reset)
        (d_command != mem_pkg::BUS_NONE) |-> (mem_command == d_command))
        else begin
            fail_count++;
            $error("data request did not get the bus");
        end

    // fetch goes out as a block load
    fetch_double: assert property (@(posedge clock) disable iff (reset)
        (mem_command != mem_pkg::BUS_NONE && d_command == mem_pkg::BUS_NONE)
            |-> (mem_command == mem_pkg::BUS_LOAD) && (mem_size == mem_pkg::DOUBLE))
        else begin
            fail_count++;
            $error("fetch request is not a DOUBLE load");
        end

    // stall exactly while data holds the grant
    stall_match: assert property (@(posedge clock) disable iff (reset)
        fetch_stall == (d_command != mem_pkg::BUS_NONE))
        else begin
            fail_count++;
            $error("fetch_stall does not follow the data grant");
        end

    // store word zero-extended
    store_upper_zero: assert property (@(posedge clock) disable iff (reset)
        (mem_command == mem_pkg::BUS_STORE) |-> (mem_data[`BLOCK_BITS-1:`XLEN] == '0))
        else begin
            fail_count++;
            $error("upper half of store data not zero");
        end

endmodule

/* tests/tb_mem_front.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_front;

    localparam int NUM_OPS        = 200;
    // generous per-op budget, covers rejects and fetch traffic
    localparam int CYCLES_PER_OP  = 100;
    localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP;
    localparam int MEM_WORDS      = 16384;
    localparam logic [31:0] FILL_KEY  = 32'h5a3c_96e1;
    localparam logic [31:0] DATA_BASE = 32'h0000_8000;

    logic clock;
    logic reset;
    mem_pkg::bus_command_t   mem_command;
    logic [`XLEN-1:0]        mem_addr;
    logic [`BLOCK_BITS-1:0]  mem_data;
    mem_pkg::mem_size_t      mem_size;
    logic [`MEM_TAG_BITS-1:0] mem_response;
    logic [`MEM_TAG_BITS-1:0] mem_reply_tag;
    logic [`BLOCK_BITS-1:0]  mem_reply_data;
    mem_pkg::bus_command_t   dmem_command;
    logic [`XLEN-1:0]        dmem_addr;
    logic [`XLEN-1:0]        dmem_wdata;
    mem_pkg::mem_size_t      dmem_size;
    logic                    dmem_busy;
    logic                    dmem_done;
    logic [`XLEN-1:0]        dmem_rdata;
    logic                    redirect;
    logic [`XLEN-1:0]        redirect_pc;
    mem_pkg::fetch_packet_t  fetch_packet;
    logic                    fetch_stall;

    // memory model and expected data
    logic [31:0] mem_words [0:MEM_WORDS-1];
    logic [31:0] shadow [0:MEM_WORDS-1];
    logic [`MEM_TAG_BITS-1:0] next_tag;
    logic [`MEM_TAG_BITS-1:0] pipe_tag [0:1];
    logic [`BLOCK_BITS-1:0]   pipe_data [0:1];
    logic        reject_q;
    integer      seed;
    // stimulus and checker state
    logic        op_waiting;
    logic        cur_is_load;
    logic [31:0] cur_expect;
    int          ops_done;
    int          ops_sent;
    int          cycles;
    logic        after_redirect;
    logic [31:0] prev_pc;
    logic [31:0] target_pc;

    tb_clock u_tb_clock (.clock(clock), .reset(reset));

    mem_front u_mem_front (.*);

    bind mem_front mem_front_asserts u_mem_front_asserts (
        .clock(clock), .reset(reset), .mem_command(mem_command), .mem_data(mem_data),
        .mem_size(mem_size), .d_command(d_port.command), .dmem_busy(dmem_busy),
        .dmem_done(dmem_done), .fetch_valid(fetch_packet.valid),
        .fetch_stall(fetch_stall)
    );

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[15:2]);
    endfunction

    task automatic report_failure(input string what);
        $display("[FAIL] %0t ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        seed = 32'he75f;
        // every word starts as its own address mixed with a key
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = (i << 2) ^ FILL_KEY;
            shadow[i]    = (i << 2) ^ FILL_KEY;
        end
        dmem_command = mem_pkg::BUS_NONE;
        {dmem_addr, dmem_wdata} = '0;
        dmem_size = mem_pkg::WORD;
        {redirect, redirect_pc, mem_reply_tag, mem_reply_data, reject_q} = '0;
        next_tag = 1;
        pipe_tag[0] = '0;
        pipe_tag[1] = '0;
        {op_waiting, cur_is_load, cur_expect, ops_done, ops_sent} = '0;
        prev_pc = '0;
        // first packet out of reset must come from the reset pc
        after_redirect = 1'b1;
        target_pc = `RESET_PC;
    end

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    // accept in the same cycle unless this cycle is a reject
    assign mem_response = (mem_command != mem_pkg::BUS_NONE && !reject_q) ? next_tag : '0;

    always @(posedge clock) begin
        pipe_tag[0] <= '0;
        if (mem_response != '0) begin
            next_tag <= (next_tag == '1) ? 1 : next_tag + 1;
            if (mem_command == mem_pkg::BUS_STORE) begin
                mem_words[word_index(mem_addr)] <= mem_data[31:0];
            end else begin
                pipe_tag[0]  <= mem_response;
                pipe_data[0] <= {mem_words[word_index({mem_addr[31:3], 3'b100})],
                                 mem_words[word_index({mem_addr[31:3], 3'b000})]};
            end
        end
        // reply seen by the DUT three edges after the accept
        pipe_tag[1]    <= pipe_tag[0];
        pipe_data[1]   <= pipe_data[0];
        mem_reply_tag  <= pipe_tag[1];
        mem_reply_data <= pipe_data[1];
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    always @(posedge clock) begin
        if (!reset) begin
            reject_q <= (($random(seed) & 7) == 0);
            redirect <= 1'b0;
            if (($random(seed) & 63) == 0) begin
                redirect    <= 1'b1;
                redirect_pc <= $random(seed) & 32'h0000_03fc;
            end
            // one-cycle strobe per data op
            dmem_command <= mem_pkg::BUS_NONE;
            if (op_waiting && dmem_done) begin
                op_waiting <= 1'b0;
                ops_done   <= ops_done + 1;
            end else if (!op_waiting && !dmem_busy && ops_sent < NUM_OPS) begin
                dmem_addr  <= DATA_BASE | ($random(seed) & 32'h0000_00fc);
                dmem_wdata <= $random(seed);
                op_waiting <= 1'b1;
                ops_sent   <= ops_sent + 1;
                if ($random(seed) & 1) begin
                    dmem_command <= mem_pkg::BUS_LOAD;
                    cur_is_load  <= 1'b1;
                end else begin
                    dmem_command <= mem_pkg::BUS_STORE;
                    cur_is_load  <= 1'b0;
                end
            end
        end
    end

    // expected values follow the stimulus one op at a time
    always @(posedge clock) begin
        if (dmem_command == mem_pkg::BUS_STORE) begin
            shadow[word_index(dmem_addr)] <= dmem_wdata;
        end else if (dmem_command == mem_pkg::BUS_LOAD) begin
            cur_expect <= shadow[word_index(dmem_addr)];
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    always @(posedge clock) begin
        if (!reset && fetch_packet.valid) begin
            assert (fetch_packet.inst == mem_words[word_index(fetch_packet.pc)])
                else report_failure("fetched word differs from memory");
            assert (fetch_packet.npc == fetch_packet.pc + 32'd4)
                else report_failure("npc is not pc + 4");
            if (after_redirect) begin
                assert (fetch_packet.pc == target_pc)
                    else report_failure("first packet not at the redirect target");
            end else begin
                assert (fetch_packet.pc == prev_pc + 32'd4)
                    else report_failure("fetch pc did not step by 4");
            end
            prev_pc        <= fetch_packet.pc;
            after_redirect <= 1'b0;
        end
        // redirect takes effect at this edge
        if (redirect) begin
            after_redirect <= 1'b1;
            target_pc      <= redirect_pc;
        end
        if (op_waiting && dmem_done && cur_is_load) begin
            assert (dmem_rdata == cur_expect)
                else report_failure("load data differs from last store");
        end
        if (u_mem_front.u_mem_front_asserts.fail_count != 0) begin
            report_failure("a bound assertion on mem_front failed");
        end
    end

    // run length and timeout
    initial begin
        cycles = 0;
        while (ops_done < NUM_OPS && cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        if (ops_done < NUM_OPS) begin
            $display("timeout: %0d of %0d data operations done after %0d cycles",
                     ops_done, NUM_OPS, cycles);
            $display("TEST FAIL");
            $fatal(1, "run did not finish in time");
        end else if (u_mem_front.u_mem_front_asserts.fail_count != 0) begin
            $display("TEST FAIL");
            $fatal(1, "bound assertions failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+src
src/mem_pkg.sv
src/mem_port_if.sv
src/mem_arbiter.sv
src/fetch_unit.sv
src/data_port.sv
src/mem_front.sv
tests/tb_clock.sv
tests/mem_front_asserts.sv
tests/tb_mem_front.sv

/* Bender.yml */
package:
  name: mem_front

sources:
  - include_dirs:
      - src
    files:
      - src/mem_pkg.sv
      - src/mem_port_if.sv
      - src/mem_arbiter.sv
      - src/fetch_unit.sv
      - src/data_port.sv
      - src/mem_front.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_clock.sv
      - tests/mem_front_asserts.sv
      - tests/tb_mem_front.sv
